/* design/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath width, fixed by rv32
`define XLEN 32

// rv32e register file, low four index bits only
`define NREGS  16
`define REG_AW $clog2(`NREGS)

// csr address field of the system opcode
`define CSR_AW 12

// machine csr reset and constant values
`define MSTATUS_RESET   32'h0000_1800
`define MVENDORID_VALUE 32'h7973_7978
`define MARCHID_VALUE   32'h017d_9f58

`endif

/* design/isa_pkg.sv */
`include "core_macros.svh"

package isa_pkg;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_JALR  = 3'b000;
  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;
  localparam logic [2:0] F3_PRIV  = 3'b000;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // funct12 of the privileged system ops
  localparam logic [11:0] F12_ECALL = 12'h000;
  localparam logic [11:0] F12_MRET  = 12'h302;

  typedef enum logic [`CSR_AW-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MTVEC     = 12'h305,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MVENDORID = 12'hf11,
    CSR_MARCHID   = 12'hf12
  } csr_addr_e;

  typedef enum logic [`XLEN-1:0] {
    CAUSE_MISALIGNED = 32'd0,
    CAUSE_ILLEGAL    = 32'd2,
    CAUSE_ECALL      = 32'd11
  } trap_cause_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } inst_u;

endpackage

/* design/pipe_pkg.sv */
`include "core_macros.svh"

package pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_B,
    ALU_CSR_RW,
    ALU_CSR_SET
  } alu_op_e;

  typedef enum logic [2:0] {
    CTRL_NONE,
    CTRL_BRANCH_EQ,
    CTRL_BRANCH_NE,
    CTRL_JAL,
    CTRL_JALR,
    CTRL_ECALL,
    CTRL_MRET,
    CTRL_ILLEGAL
  } ctrl_kind_e;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   src1;
    logic [`XLEN-1:0]   src2;   // rs2, immediate or old csr value
    logic [`XLEN-1:0]   imm;
    alu_op_e            alu_op;
    ctrl_kind_e         ctrl_kind;
    logic [`CSR_AW-1:0] csr_addr;
    logic               writes_rd;
  } decoded_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   npc;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   wdata;
    logic               writes_rd;
    logic [`CSR_AW-1:0] csr_addr;
    logic               csr_wen;
    logic [`XLEN-1:0]   csr_wdata;
    ctrl_kind_e         ctrl_kind;
    logic               misaligned;
  } result_t;

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   npc;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   wdata;
    logic               writes_rd;
  } retire_t;

  typedef struct packed {
    logic [`XLEN-1:0]     target;
    isa_pkg::trap_cause_e cause;
  } redirect_t;

endpackage

/* design/decode_stage.sv */
`include "core_macros.svh"

module decode_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               flush,
  input  logic               inst_valid,
  input  logic [`XLEN-1:0]   inst_pc,
  input  isa_pkg::inst_u     inst,
  output logic [`REG_AW-1:0] rs1,
  output logic [`REG_AW-1:0] rs2,
  output logic [`CSR_AW-1:0] csr_addr,
  input  logic [`XLEN-1:0]   src1,
  input  logic [`XLEN-1:0]   src2,
  input  logic [`XLEN-1:0]   csr_rdata,
  output pipe_pkg::decoded_t decoded
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [`XLEN-1:0] imm;
  alu_op_e          alu_op;
  ctrl_kind_e       ctrl_kind;
  logic             writes_rd;
  logic             uses_rs2;
  logic             is_csr;
  decoded_t         next;

  always_comb begin
    imm       = '0;
    alu_op    = ALU_ADD;
    ctrl_kind = CTRL_NONE;
    writes_rd = 1'b1;
    uses_rs2  = 1'b0;
    is_csr    = 1'b0;
    case (inst.r_fmt.opcode)
      OP_LUI: begin
        imm    = {inst.j_fmt.imm20, inst.j_fmt.imm10_1, inst.j_fmt.imm11,
                  inst.j_fmt.imm19_12, 12'b0}; // u-type upper bits
        alu_op = ALU_PASS_B;
      end
      OP_JAL: begin
        imm       = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                     inst.j_fmt.imm10_1, 1'b0};
        ctrl_kind = CTRL_JAL;
      end
      OP_JALR: begin
        imm       = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        ctrl_kind = (inst.i_fmt.funct3 == F3_JALR) ? CTRL_JALR : CTRL_ILLEGAL;
      end
      OP_BRANCH: begin
        imm       = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
                     inst.b_fmt.imm4_1, 1'b0};
        uses_rs2  = 1'b1;
        writes_rd = 1'b0;
        case (inst.b_fmt.funct3)
          F3_BEQ:  ctrl_kind = CTRL_BRANCH_EQ;
          F3_BNE:  ctrl_kind = CTRL_BRANCH_NE;
          default: ctrl_kind = CTRL_ILLEGAL;
        endcase
      end
      OP_IMM: begin
        imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        if (inst.i_fmt.funct3 != F3_ADD) ctrl_kind = CTRL_ILLEGAL;
      end
      OP_REG: begin
        uses_rs2 = 1'b1;
        if (inst.r_fmt.funct3 != F3_ADD) ctrl_kind = CTRL_ILLEGAL;
        else if (inst.r_fmt.funct7 == F7_SUB) alu_op = ALU_SUB;
        else if (inst.r_fmt.funct7 != F7_ADD) ctrl_kind = CTRL_ILLEGAL;
      end
      OP_SYSTEM: begin
        case (inst.i_fmt.funct3)
          F3_CSRRW: begin
            is_csr = 1'b1;
            alu_op = ALU_CSR_RW;
          end
          F3_CSRRS: begin
            is_csr = 1'b1;
            alu_op = ALU_CSR_SET;
          end
          F3_PRIV: begin
            writes_rd = 1'b0;
            if (inst.i_fmt.imm == F12_ECALL) ctrl_kind = CTRL_ECALL;
            else if (inst.i_fmt.imm == F12_MRET) ctrl_kind = CTRL_MRET;
            else ctrl_kind = CTRL_ILLEGAL;
          end
          default: ctrl_kind = CTRL_ILLEGAL;
        endcase
      end
      default: ctrl_kind = CTRL_ILLEGAL;
    endcase
    if (ctrl_kind == CTRL_ILLEGAL) writes_rd = 1'b0;
  end

  // read ports into the commit stage
  assign rs1      = inst.r_fmt.rs1[`REG_AW-1:0];
  assign rs2      = uses_rs2 ? inst.r_fmt.rs2[`REG_AW-1:0] : '0; // x0 keeps rs2 out of forwarding
  assign csr_addr = inst.i_fmt.imm;

  always_comb begin
    next.valid     = inst_valid;
    next.pc        = inst_pc;
    next.rs1       = rs1;
    next.rs2       = rs2;
    next.rd        = inst.r_fmt.rd[`REG_AW-1:0];
    next.src1      = src1;
    next.src2      = is_csr ? csr_rdata : (uses_rs2 ? src2 : imm);
    next.imm       = imm;
    next.alu_op    = alu_op;
    next.ctrl_kind = ctrl_kind;
    next.csr_addr  = csr_addr;
    next.writes_rd = writes_rd;
  end

  always_ff @(posedge clock) begin
    decoded <= next;
    if (reset || flush) begin
      decoded.valid <= 1'b0;
    end
  end

endmodule

/* design/execute_stage.sv */
`include "core_macros.svh"

module execute_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               flush,
  input  pipe_pkg::decoded_t decoded,
  output pipe_pkg::result_t  result
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] target;
  logic             fwd_ok;
  logic             is_csr;
  logic             csr_writable;
  logic             is_jump;
  logic             taken;
  logic             misaligned;
  result_t          next;

  assign fwd_ok  = result.valid && result.writes_rd && (result.rd != '0);
  assign is_csr  = (decoded.alu_op == ALU_CSR_RW) || (decoded.alu_op == ALU_CSR_SET);
  assign is_jump = (decoded.ctrl_kind == CTRL_JAL) || (decoded.ctrl_kind == CTRL_JALR);
  assign link    = decoded.pc + `XLEN'(4);

  // operands, with the instruction one ahead forwarded
  always_comb begin
    op_a = decoded.src1;
    op_b = decoded.src2;
    if (fwd_ok && result.rd == decoded.rs1) op_a = result.wdata;
    if (fwd_ok && result.rd == decoded.rs2) op_b = result.wdata;
    if (is_csr && result.valid && result.csr_wen && result.csr_addr == decoded.csr_addr) begin
      op_b = result.csr_wdata; // back-to-back csr access
    end
  end

  always_comb begin
    case (decoded.csr_addr)
      CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE: csr_writable = 1'b1;
      default: csr_writable = 1'b0;
    endcase
  end

  always_comb begin
    case (decoded.alu_op)
      ALU_ADD:     alu_out = op_a + op_b;
      ALU_SUB:     alu_out = op_a - op_b;
      ALU_PASS_B:  alu_out = op_b;
      ALU_CSR_RW:  alu_out = op_b; // old csr value to rd
      ALU_CSR_SET: alu_out = op_b;
      default:     alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    target = decoded.pc + decoded.imm;
    case (decoded.ctrl_kind)
      CTRL_BRANCH_EQ: taken = (op_a == op_b);
      CTRL_BRANCH_NE: taken = (op_a != op_b);
      CTRL_JAL:       taken = 1'b1;
      CTRL_JALR: begin
        taken  = 1'b1;
        target = (op_a + decoded.imm) & {{(`XLEN-1){1'b1}}, 1'b0};
      end
      default:        taken = 1'b0;
    endcase
  end

  assign misaligned = taken && (target[1:0] != 2'b00);

  always_comb begin
    next.valid      = decoded.valid;
    next.pc         = decoded.pc;
    next.npc        = taken ? target : link;
    next.rd         = decoded.rd;
    next.wdata      = is_jump ? link : alu_out;
    next.writes_rd  = decoded.writes_rd && !misaligned;
    next.csr_addr   = decoded.csr_addr;
    next.csr_wen    = is_csr && csr_writable;
    next.csr_wdata  = (decoded.alu_op == ALU_CSR_SET) ? (op_b | op_a) : op_a;
    next.ctrl_kind  = decoded.ctrl_kind;
    next.misaligned = misaligned;
  end

  always_ff @(posedge clock) begin
    result <= next;
    if (reset || flush) begin
      result.valid <= 1'b0;
    end
  end

endmodule

/* design/commit_stage.sv */
`include "core_macros.svh"

module commit_stage (
  input  logic                clock,
  input  logic                reset,
  input  pipe_pkg::result_t   result,
  input  logic [`REG_AW-1:0]  rs1,
  input  logic [`REG_AW-1:0]  rs2,
  input  logic [`CSR_AW-1:0]  csr_addr,
  output logic [`XLEN-1:0]    src1,
  output logic [`XLEN-1:0]    src2,
  output logic [`XLEN-1:0]    csr_rdata,
  output logic                retire_valid,
  output pipe_pkg::retire_t   retire,
  output logic                redirect_valid,
  output pipe_pkg::redirect_t redirect,
  output logic                flush
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [`XLEN-1:0] regs [`NREGS];
  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;
  logic [`XLEN-1:0] mcause;
  logic [`XLEN-1:0] csr_value;
  logic [`XLEN-1:0] next_pc;
  logic             live;
  logic             trap;
  logic             mret;
  logic             rd_wen;
  logic             csr_wen;
  logic             redirects;
  trap_cause_e      cause;

  assign flush = redirect_valid;

  // a wrong-path result is still in the stage during the flush cycle
  assign live = result.valid && !flush;
  assign mret = (result.ctrl_kind == CTRL_MRET);

  always_comb begin
    trap  = 1'b1;
    cause = CAUSE_MISALIGNED; // plain redirects carry 0 too
    if (result.ctrl_kind == CTRL_ECALL) cause = CAUSE_ECALL;
    else if (result.ctrl_kind == CTRL_ILLEGAL) cause = CAUSE_ILLEGAL;
    else if (!result.misaligned) trap = 1'b0;
  end

  assign rd_wen    = live && !trap && result.writes_rd && (result.rd != '0);
  assign csr_wen   = live && !trap && result.csr_wen;
  assign next_pc   = trap ? mtvec : (mret ? mepc : result.npc);
  assign redirects = trap || mret || (result.npc != result.pc + `XLEN'(4));

  // write on this edge passes straight to decode, x0 is never written
  assign src1 = (rd_wen && result.rd == rs1) ? result.wdata : regs[rs1];
  assign src2 = (rd_wen && result.rd == rs2) ? result.wdata : regs[rs2];

  always_comb begin
    case (csr_addr)
      CSR_MSTATUS:   csr_value = mstatus;
      CSR_MTVEC:     csr_value = mtvec;
      CSR_MEPC:      csr_value = mepc;
      CSR_MCAUSE:    csr_value = mcause;
      CSR_MVENDORID: csr_value = `MVENDORID_VALUE;
      CSR_MARCHID:   csr_value = `MARCHID_VALUE;
      default:       csr_value = '0;
    endcase
  end

  assign csr_rdata = (csr_wen && result.csr_addr == csr_addr) ? result.csr_wdata : csr_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
      mstatus        <= `MSTATUS_RESET;
      mtvec          <= '0;
      mepc           <= '0;
      mcause         <= '0;
      retire_valid   <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      retire_valid   <= live;
      redirect_valid <= live && redirects;
      if (rd_wen) begin
        regs[result.rd] <= result.wdata;
      end
      if (live && trap) begin
        mcause <= cause;
        mepc   <= result.pc;
      end
      if (csr_wen) begin
        case (result.csr_addr)
          CSR_MSTATUS: mstatus <= result.csr_wdata;
          CSR_MTVEC:   mtvec   <= result.csr_wdata;
          CSR_MEPC:    mepc    <= result.csr_wdata;
          CSR_MCAUSE:  mcause  <= result.csr_wdata;
          default: ; // read-only or unknown
        endcase
      end
    end
  end

  // retire and redirect records, qualified by their valid pulses
  always_ff @(posedge clock) begin
    retire.pc        <= result.pc;
    retire.npc       <= next_pc;
    retire.rd        <= result.rd;
    retire.wdata     <= result.wdata;
    retire.writes_rd <= result.writes_rd && !trap;
    redirect.target  <= next_pc;
    redirect.cause   <= cause;
  end

endmodule

/* design/rv_core.sv */
`include "core_macros.svh"

module rv_core (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  input  logic [`XLEN-1:0]    inst_pc,
  input  isa_pkg::inst_u      inst,
  output logic                retire_valid,
  output pipe_pkg::retire_t   retire,
  output logic                redirect_valid,
  output pipe_pkg::redirect_t redirect
);
  import pipe_pkg::*;

  decoded_t           decoded;
  result_t            result;
  logic               flush;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  logic [`CSR_AW-1:0] csr_addr;
  logic [`XLEN-1:0]   src1;
  logic [`XLEN-1:0]   src2;
  logic [`XLEN-1:0]   csr_rdata;

  decode_stage decode0 (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .inst_valid (inst_valid),
    .inst_pc    (inst_pc),
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .csr_addr   (csr_addr),
    .src1       (src1),
    .src2       (src2),
    .csr_rdata  (csr_rdata),
    .decoded    (decoded)
  );

  execute_stage execute0 (
    .clock   (clock),
    .reset   (reset),
    .flush   (flush),
    .decoded (decoded),
    .result  (result)
  );

  // register file and csrs live here
  commit_stage commit0 (
    .clock          (clock),
    .reset          (reset),
    .result         (result),
    .rs1            (rs1),
    .rs2            (rs2),
    .csr_addr       (csr_addr),
    .src1           (src1),
    .src2           (src2),
    .csr_rdata      (csr_rdata),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .redirect_valid (redirect_valid),
    .redirect       (redirect),
    .flush          (flush)
  );

endmodule

/* bench/core_asserts.sv */
module core_asserts (
  input logic clock,
  input logic reset,
  input logic retire_valid,
  input logic redirect_valid
);

  // redirect is a single-cycle pulse
  redirect_one_cycle: assert property (
    @(posedge clock) disable iff (reset)
    redirect_valid |=> !redirect_valid
  ) else $error("redirect_valid stayed high for more than one cycle");

  // the flush cycle retires nothing
  quiet_after_redirect: assert property (
    @(posedge clock) disable iff (reset)
    redirect_valid |=> !retire_valid
  ) else $error("retire_valid high in the cycle after a redirect");

  outputs_low_in_reset: assert property (
    @(posedge clock)
    reset |=> (!retire_valid && !redirect_valid)
  ) else $error("retire or redirect active while reset was high");

endmodule

bind rv_core core_asserts asserts0 (
  .clock          (clock),
  .reset          (reset),
  .retire_valid   (retire_valid),
  .redirect_valid (redirect_valid)
);

/* bench/core_tb.sv */
module core_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int VEC_WORDS = 1024;
  localparam int PROG_LEN_AT = 'h100;
  localparam int RET_COUNT_AT = 'h101;
  localparam int RET_BASE = 'h102;
  localparam int RED_COUNT_AT = 'h300;
  localparam int RED_BASE = 'h301;

  logic        clock;
  logic        reset;
  logic        inst_valid;
  logic [31:0] inst_pc;
  inst_u       inst;
  logic        retire_valid;
  retire_t     retire;
  logic        redirect_valid;
  redirect_t   redirect;

  logic [31:0] vec [VEC_WORDS];
  logic [15:0] lfsr;
  logic [31:0] fetch_pc;
  int          prog_len;
  int          rcount;
  int          dcount;
  int          ri;
  int          di;

  rv_core dut0 (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .inst_pc        (inst_pc),
    .inst           (inst),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .redirect_valid (redirect_valid),
    .redirect       (redirect)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b = lfsr[0];
  endtask

  function automatic logic [31:0] fetch_word(input logic [31:0] pc);
    int idx;
    idx = int'(pc[31:2]);
    return (idx < prog_len) ? vec[idx] : 32'h0; // past the program reads as illegal
  endfunction

  task automatic check_retire(input retire_t got);
    retire_t exp;
    int base;
    base = RET_BASE + 5 * ri;
    if (ri >= rcount) begin
      fail_run("a retire arrived after the expected retire trace was used up");
    end else begin
      exp.pc        = vec[base];
      exp.npc       = vec[base + 1];
      exp.rd        = vec[base + 2][3:0];
      exp.wdata     = vec[base + 3];
      exp.writes_rd = vec[base + 4][0];
      if (got.pc !== exp.pc || got.npc !== exp.npc || got.writes_rd !== exp.writes_rd ||
          (exp.writes_rd && (got.rd !== exp.rd || got.wdata !== exp.wdata))) begin
        $display("Mismatch at %0t: retire %0d got pc %h npc %h rd %0d wdata %h wr %b",
                 $time, ri, got.pc, got.npc, got.rd, got.wdata, got.writes_rd);
        $display("  expected pc %h npc %h rd %0d wdata %h wr %b",
                 exp.pc, exp.npc, exp.rd, exp.wdata, exp.writes_rd);
        fail_run("retire record differs from the expected trace");
      end else begin
        ri++;
      end
    end
  endtask

  task automatic check_redirect(input redirect_t got);
    redirect_t exp;
    int base;
    base = RED_BASE + 2 * di;
    if (di >= dcount) begin
      fail_run("a redirect arrived after the expected redirect trace was used up");
    end else begin
      exp.target = vec[base];
      exp.cause  = trap_cause_e'(vec[base + 1]);
      if (got.target !== exp.target || got.cause !== exp.cause) begin
        $display("Mismatch at %0t: redirect %0d got target %h cause %0d, expected %h cause %0d",
                 $time, di, got.target, got.cause, exp.target, exp.cause);
        fail_run("redirect record differs from the expected trace");
      end else begin
        di++;
      end
    end
  endtask

  // watchdog, scaled by program length
  initial begin
    longint limit;
    #1;
    limit = (longint'(prog_len) * 20 + 200 + 8) * 100;
    #(limit);
    fail_run("the run timed out before the retire and redirect trace completed");
  end

  initial begin
    logic done;
    logic b0;
    logic b1;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst_pc    = '0;
    inst       = '0;
    for (int i = 0; i < VEC_WORDS; i++) begin
      vec[i] = '0;
    end
    $readmemh("bench/core_vectors.txt", vec);
    prog_len = int'(vec[PROG_LEN_AT]);
    rcount   = int'(vec[RET_COUNT_AT]);
    dcount   = int'(vec[RED_COUNT_AT]);
    ri       = 0;
    di       = 0;
    lfsr     = 16'd55;
    fetch_pc = '0;
    done     = 1'b0;

    repeat (8) @(posedge clock);
    #10 reset = 1'b0;

    while (!done) begin
      @(posedge clock);
      #10;
      if (retire_valid) check_retire(retire);
      if (redirect_valid) check_redirect(redirect);
      done = retire_valid && (retire.npc == retire.pc); // final self-loop retired
      if (redirect_valid) begin
        inst_valid = 1'b0; // flush cycle
        fetch_pc   = redirect.target;
      end else if (done) begin
        inst_valid = 1'b0;
      end else begin
        take_bit(b0);
        take_bit(b1);
        if (b0 && b1) begin
          inst_valid = 1'b0;
        end else begin
          inst_valid = 1'b1;
          inst_pc    = fetch_pc;
          inst       = fetch_word(fetch_pc);
          fetch_pc   = fetch_pc + 32'd4;
        end
      end
    end

    // nothing may retire once the trace is complete
    repeat (6) begin
      @(posedge clock);
      #10;
      if (retire_valid) check_retire(retire);
      if (redirect_valid) check_redirect(redirect);
    end

    if (ri != rcount || di != dcount) begin
      fail_run("the run ended with expected records left over");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

/* bench/core_vectors.txt */
// program words from pc 0, then retire records: pc npc rd wdata writes_rd
// then redirect records: target cause
@000
00500093 00708113 002081b3 40118233
123452b7 004282b3 00908013 00100333
00608463 00100393 00609463 00209463
00200393 00208463 0080046f 00300393
05000493 00048567 00400393 00500393
08400593 30559673 305026f3 3000a773
300017f3 f1102773 f12096f3 f12026f3
7c00a673 00000073 002481e7 00000000
0000006f 342020f3 34102173 00410113
34111073 30200073
@100
00000026 0000002b
00000000 00000004 1 00000005 1
00000004 00000008 2 0000000c 1
00000008 0000000c 3 00000011 1
0000000c 00000010 4 0000000c 1
00000010 00000014 5 12345000 1
00000014 00000018 5 1234500c 1
00000018 0000001c 0 0000000e 1
0000001c 00000020 6 00000005 1
00000020 00000028 0 00000000 0
00000028 0000002c 0 00000000 0
0000002c 00000034 0 00000000 0
00000034 00000038 0 00000000 0
00000038 00000040 8 0000003c 1
00000040 00000044 9 00000050 1
00000044 00000050 a 00000048 1
00000050 00000054 b 00000084 1
00000054 00000058 c 00000000 1
00000058 0000005c d 00000084 1
0000005c 00000060 e 00001800 1
00000060 00000064 f 00001805 1
00000064 00000068 e 79737978 1
00000068 0000006c d 017d9f58 1
0000006c 00000070 d 017d9f58 1
00000070 00000074 c 00000000 1
00000074 00000084 0 00000000 0
00000084 00000088 1 0000000b 1
00000088 0000008c 2 00000074 1
0000008c 00000090 2 00000078 1
00000090 00000094 0 00000074 1
00000094 00000078 0 00000000 0
00000078 00000084 0 00000000 0
00000084 00000088 1 00000000 1
00000088 0000008c 2 00000078 1
0000008c 00000090 2 0000007c 1
00000090 00000094 0 00000078 1
00000094 0000007c 0 00000000 0
0000007c 00000084 0 00000000 0
00000084 00000088 1 00000002 1
00000088 0000008c 2 0000007c 1
0000008c 00000090 2 00000080 1
00000090 00000094 0 0000007c 1
00000094 00000080 0 00000000 0
00000080 00000080 0 00000084 1
@300
0000000b
00000028 00000000
00000034 00000000
00000040 00000000
00000050 00000000
00000084 0000000b
00000078 00000000
00000084 00000000
0000007c 00000000
00000084 00000002
00000080 00000000
00000080 00000000

/* tb.f */
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/decode_stage.sv
design/execute_stage.sv
design/commit_stage.sv
design/rv_core.sv
bench/core_asserts.sv
bench/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run from the project root
rm -f build.log sim.log
verilator --binary --assert --top-module core_tb -f tb.f -o core_sim > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/core_sim > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
exit 0
